/* bench/clockGen.sv */
// Testbench clock and synchronous reset source, with a restart input for a new section
`timescale 1ns/1ns
module clockGen #(
   parameter int period = 20,
   parameter int resetCycles = 10
) (
   input  logic again,
   output logic clk,
   output logic reset
);

   int count;

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      count = 0;
   end

   always #(period / 2) clk = ~clk;

   // Reset holds for resetCycles rising edges; again starts it over
   always @(posedge clk) begin
      if (again) begin
         reset <= 1'b1;
         count <= 0;
      end else if (count < resetCycles - 1) begin
         count <= count + 1;
      end else begin
         reset <= 1'b0;
      end
   end

endmodule

/* bench/procTb.sv */
// Testbench for the multi-cycle core, loading programs and checking the event traces
`timescale 1ns/1ns
module procTb import procPkg::*; ();

   localparam int maxRecords = 256;

   logic clk, reset, again, run;
   logic loadReq, loadGnt;
   logic [wordWidth-1:0] loadAddr, loadData;
   logic wbValid, stValid, halted, err;
   logic [regSel-1:0] wbReg;
   logic [wordWidth-1:0] wbData, stAddr, stData;

   logic [63:0] kinds [maxRecords];
   logic [wordWidth-1:0] aVals [maxRecords];
   logic [wordWidth-1:0] bVals [maxRecords];
   int numRecords = 0;
   int watchLimit = 0;

   clockGen #(.period(20), .resetCycles(10)) clocks0 (.again, .clk, .reset);

   proc #(.memWords(256)) dut (
      .clk, .reset, .run, .loadReq, .loadAddr, .loadData, .loadGnt,
      .wbValid, .wbReg, .wbData, .stValid, .stAddr, .stData, .halted, .err
   );

   task automatic failRun(input string what);
      $display("%s", what);
      $display("Checks failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic checkWb(input string name, input logic [regSel-1:0] expReg,
                          input logic [wordWidth-1:0] expData, input logic [regSel-1:0] actReg,
                          input logic [wordWidth-1:0] actData);
      if (actReg !== expReg || actData !== expData) begin
         failRun($sformatf("error %s expected r%0d=%h actual r%0d=%h",
                           name, expReg, expData, actReg, actData));
      end
   endtask

   task automatic checkSt(input string name, input logic [wordWidth-1:0] expAddr,
                          input logic [wordWidth-1:0] expData, input logic [wordWidth-1:0] actAddr,
                          input logic [wordWidth-1:0] actData);
      if (actAddr !== expAddr || actData !== expData) begin
         failRun($sformatf("error %s expected [%h]=%h actual [%h]=%h",
                           name, expAddr, expData, actAddr, actData));
      end
   endtask

   task automatic checkHalt(input string name, input logic expErr, input logic actHalted,
                            input logic actErr);
      if (actHalted !== 1'b1 || actErr !== expErr) begin
         failRun($sformatf("error %s expected halted=1 err=%b actual halted=%b err=%b",
                           name, expErr, actHalted, actErr));
      end
   endtask

   // Records are kept in file order; the watchdog budget follows from their count
   task automatic readRecords();
      int fd;
      int status;
      int fields;
      int numP;
      int numE;
      logic [8*96-1:0] line;
      logic [63:0] kind;
      logic [wordWidth-1:0] a;
      logic [wordWidth-1:0] b;
      numP = 0;
      numE = 0;
      fd = $fopen("bench/procTestdata.txt", "r");
      if (fd == 0) failRun("cannot open bench/procTestdata.txt for reading");
      while (!$feof(fd)) begin
         status = $fgets(line, fd);
         fields = $sscanf(line, "%s %h %h", kind, a, b);
         if (status > 0 && fields == 3 &&
             (kind == "P" || kind == "W" || kind == "S" || kind == "E")) begin
            kinds[numRecords] = kind;
            aVals[numRecords] = a;
            bVals[numRecords] = b;
            numRecords++;
            if (kind == "P") numP++;
            if (kind == "E") numE++;
         end
      end
      $fclose(fd);
      watchLimit = 40 * (numRecords - numP) + 8 * numP + 40 * numE;
   endtask

   // One loader write, with a random idle gap after it
   task automatic loadWord(input logic [wordWidth-1:0] addr, input logic [wordWidth-1:0] data);
      int gap;
      gap = $urandom % 4;
      @(posedge clk);
      loadReq <= 1'b1;
      loadAddr <= addr;
      loadData <= data;
      do @(negedge clk); while (!loadGnt);
      @(posedge clk);
      loadReq <= 1'b0;
      repeat (gap) @(posedge clk);
   endtask

   task automatic expectEvent(input int idx);
      string name;
      name = $sformatf("record %0d", idx);
      do @(negedge clk); while (!wbValid && !stValid && !halted);
      if (halted) begin
         failRun($sformatf("core halted while %s was still expected", name));
      end else if (kinds[idx] == "W") begin
         if (!wbValid) failRun($sformatf("store seen where writeback %s was expected", name));
         checkWb(name, aVals[idx][regSel-1:0], bVals[idx], wbReg, wbData);
      end else if (kinds[idx] == "S") begin
         if (!stValid) failRun($sformatf("writeback seen where store %s was expected", name));
         checkSt(name, aVals[idx], bVals[idx], stAddr, stData);
      end else begin
         failRun($sformatf("%s is not a trace record", name));
      end
   endtask

   task automatic expectHalt(input int idx);
      int quiet;
      do @(negedge clk); while (!wbValid && !stValid && !halted);
      checkHalt($sformatf("halt record %0d", idx), aVals[idx][0], halted, err);
      // Nothing may happen once the core has stopped
      for (quiet = 0; quiet < 20; quiet++) begin
         @(negedge clk);
         if (wbValid || stValid || !halted) failRun("an event was seen after the core halted");
      end
   endtask

   initial begin : watchdog
      wait (watchLimit > 0);
      repeat (watchLimit) @(posedge clk);
      failRun($sformatf("timeout after %0d cycles before the trace was complete", watchLimit));
   end

   initial begin : mainFlow
      int idx;
      int seedDummy;
      again = 1'b0;
      run = 1'b0;
      loadReq = 1'b0;
      loadAddr = '0;
      loadData = '0;
      seedDummy = $urandom(51836);
      readRecords();
      idx = 0;
      while (idx < numRecords) begin
         do @(negedge clk); while (reset);
         while (idx < numRecords && kinds[idx] == "P") begin
            loadWord(aVals[idx], bVals[idx]);
            idx++;
         end
         @(posedge clk);
         run <= 1'b1;
         while (idx < numRecords && kinds[idx] != "E") begin
            expectEvent(idx);
            idx++;
         end
         if (idx >= numRecords) failRun("a program section in the data file has no E record");
         expectHalt(idx);
         idx++;
         // The next section starts from a fresh reset
         if (idx < numRecords) begin
            @(posedge clk);
            run <= 1'b0;
            again <= 1'b1;
            @(posedge clk);
            again <= 1'b0;
         end
      end
      $display("All checks passed");
      $finish;
   end

endmodule

/* bench/procTestdata.txt */
# kind a b: P = byte address and word to load, W = register and value written back,
# S = byte address and data stored, E = err expected at the halt (b unused)
# section 1: arithmetic, memory, branches, HALT
P 0000 C125
P 0002 C2FD
P 0004 4167
P 0006 499E
P 0008 52BF
P 000A D958
P 000C E27C
P 000E ECA0
P 0010 C360
P 0012 83E4
P 0014 833E
P 0016 8B84
P 0018 8BBE
P 001A 6102
P 001C C100
P 001E 6102
P 0020 C211
P 0022 6902
P 0024 C233
P 0026 6A02
P 0028 C644
P 002A 2004
P 002C C766
P 002E 0000
P 0030 C702
P 0032 4FE1
P 0034 6FFC
P 0036 0000
P 0038 C177
W 1 0025
W 2 FFFD
W 3 002C
W 4 0027
W 5 FFE2
W 6 0022
W 7 FFD1
W 0 FFC5
W 3 0060
S 0064 FFD1
S 005E 0025
W 4 FFD1
W 5 0025
W 1 0000
W 2 0033
W 7 0002
W 7 0001
W 7 0000
E 0 0
# section 2: illegal opcode at 0004
P 0000 C10A
P 0002 4150
P 0004 F800
P 0006 C301
W 1 000A
W 2 FFFA
E 1 0

/* logic/decode.sv */
// Instruction decode, register file and the controller FSM sequencing each instruction
`timescale 1ns/1ns
module decode import procPkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 run,
   input  logic                 instrValid,
   input  logic [wordWidth-1:0] instr,
   input  logic [wordWidth-1:0] pcNext,
   output logic                 instrTake,
   output logic                 redirect,
   output logic [wordWidth-1:0] redirectPc,
   output logic [wordWidth-1:0] rsData,
   output logic [wordWidth-1:0] rtData,
   output aluOpT                aluOp,
   output logic [wordWidth-1:0] instrOut,
   output logic [wordWidth-1:0] pcOut,
   input  logic                 takeBranch,
   input  logic [wordWidth-1:0] target,
   input  logic [wordWidth-1:0] result,
   output logic                 memStart,
   output logic                 isLoad,
   output logic                 isStore,
   input  logic                 memDone,
   input  logic [wordWidth-1:0] wbValue,
   output logic                 wbValid,
   output logic [regSel-1:0]    wbReg,
   output logic [wordWidth-1:0] wbData,
   output logic                 halted,
   output logic                 err
);

   ctrlStateT state;
   logic [wordWidth-1:0] regs [2**regSel];
   logic [wordWidth-1:0] instrQ;
   logic [wordWidth-1:0] pcQ;
   opcodeT op;
   opcodeT inOp;
   logic inLegal;
   logic writesReg;

   assign op = opcodeT'(instrQ[opLo +: $bits(opcodeT)]);
   assign inOp = opcodeT'(instr[opLo +: $bits(opcodeT)]);

   assign instrTake = (state == sDecode) && instrValid;
   assign redirect = (state == sExecute) && takeBranch;
   assign redirectPc = target;
   assign rsData = regs[instrQ[rsLo +: regSel]];
   assign rtData = regs[instrQ[rtLo +: regSel]];
   assign instrOut = instrQ;
   assign pcOut = pcQ;
   assign wbValid = (state == sWriteback) && writesReg;
   // Memory stage value only matters for loads
   assign wbData = isLoad ? wbValue : result;
   assign halted = (state == sHalt);

   always_comb begin
      case (inOp)
         ADDI, SUBI, XORI, LD, ST, ADD, SUB, XOR, BEQZ, BNEZ, J, LBI, HALT: inLegal = 1'b1;
         default: inLegal = 1'b0;
      endcase
   end

   // Control for the latched instruction
   always_comb begin
      aluOp = aluAdd;
      isLoad = 1'b0;
      isStore = 1'b0;
      writesReg = 1'b1;
      wbReg = instrQ[iRdLo +: regSel];
      case (op)
         ADDI: aluOp = aluAdd;
         SUBI: aluOp = aluSub;
         XORI: aluOp = aluXor;
         LD: isLoad = 1'b1;
         ST: begin
            isStore = 1'b1;
            writesReg = 1'b0;
         end
         ADD: wbReg = instrQ[rRdLo +: regSel];
         SUB: begin
            aluOp = aluSub;
            wbReg = instrQ[rRdLo +: regSel];
         end
         XOR: begin
            aluOp = aluXor;
            wbReg = instrQ[rRdLo +: regSel];
         end
         LBI: wbReg = instrQ[rsLo +: regSel];
         default: writesReg = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= sIdle;
         memStart <= 1'b0;
         err <= 1'b0;
      end else begin
         memStart <= 1'b0;
         case (state)
            sIdle: if (run) state <= sDecode;
            sDecode: begin
               if (instrValid) begin
                  if (!inLegal) begin
                     state <= sHalt;
                     err <= 1'b1;
                  end else if (inOp == HALT) begin
                     state <= sHalt;
                  end else begin
                     state <= sExecute;
                  end
               end
            end
            sExecute: begin
               if (isLoad || isStore) begin
                  memStart <= 1'b1;
                  state <= sMemory;
               end else begin
                  state <= sWriteback;
               end
            end
            sMemory: if (memDone) state <= sWriteback;
            sWriteback: state <= sDecode;
            // sHalt holds until reset
            default: state <= sHalt;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (instrTake) begin
         instrQ <= instr;
         pcQ <= pcNext;
      end
      if (wbValid) begin
         regs[wbReg] <= wbData;
      end
   end

endmodule

/* logic/execute.sv */
// Execute stage with ALU, immediate extension and branch target resolution
`timescale 1ns/1ns
module execute import procPkg::*; (
   input  logic [wordWidth-1:0] instr,
   input  logic [wordWidth-1:0] rsData,
   input  logic [wordWidth-1:0] rtData,
   input  aluOpT                aluOp,
   input  logic [wordWidth-1:0] pcNext,
   output logic [wordWidth-1:0] result,
   output logic                 takeBranch,
   output logic [wordWidth-1:0] target
);

   opcodeT op;
   logic [wordWidth-1:0] imm5s;
   logic [wordWidth-1:0] imm5z;
   logic [wordWidth-1:0] imm8s;
   logic [wordWidth-1:0] imm11s;
   logic [wordWidth-1:0] operand;
   logic [wordWidth-1:0] aluOut;

   assign op = opcodeT'(instr[opLo +: $bits(opcodeT)]);

   assign imm5s = {{(wordWidth - imm5Bits){instr[imm5Bits-1]}}, instr[0 +: imm5Bits]};
   assign imm5z = {{(wordWidth - imm5Bits){1'b0}}, instr[0 +: imm5Bits]};
   assign imm8s = {{(wordWidth - imm8Bits){instr[imm8Bits-1]}}, instr[0 +: imm8Bits]};
   assign imm11s = {{(wordWidth - imm11Bits){instr[imm11Bits-1]}}, instr[0 +: imm11Bits]};

   always_comb begin
      case (op)
         ADDI, SUBI, LD, ST: operand = imm5s;
         XORI: operand = imm5z;
         default: operand = rtData;
      endcase
      case (aluOp)
         aluSub: aluOut = rsData - operand;
         aluXor: aluOut = rsData ^ operand;
         default: aluOut = rsData + operand;
      endcase
      // LBI bypasses the ALU
      result = (op == LBI) ? imm8s : aluOut;
   end

   // Branches are relative to the following instruction
   always_comb begin
      target = pcNext + imm8s;
      case (op)
         BEQZ: takeBranch = (rsData == '0);
         BNEZ: takeBranch = (rsData != '0);
         J: begin
            takeBranch = 1'b1;
            target = pcNext + imm11s;
         end
         default: takeBranch = 1'b0;
      endcase
   end

endmodule

/* logic/fetch.sv */
// Fetch unit holding the program counter and a one-entry prefetch buffer
`timescale 1ns/1ns
module fetch import procPkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 run,
   output logic                 fetchReq,
   output logic [wordWidth-1:0] fetchAddr,
   input  logic                 fetchGnt,
   input  logic                 fetchRdValid,
   input  logic [wordWidth-1:0] rdata,
   input  logic                 instrTake,
   input  logic                 redirect,
   input  logic [wordWidth-1:0] redirectPc,
   output logic                 instrValid,
   output logic [wordWidth-1:0] instr,
   output logic [wordWidth-1:0] pcNext
);

   logic [wordWidth-1:0] pc;
   logic bufValid;
   logic stale;
   logic liveRet;

   assign liveRet = fetchRdValid && !stale;
   // At most one word buffered or on its way
   assign fetchReq = run && (!bufValid || instrTake) && !liveRet;
   assign fetchAddr = pc;
   assign instrValid = bufValid;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
         bufValid <= 1'b0;
         stale <= 1'b0;
      end else begin
         // A read granted during a redirect brings back the wrong word
         stale <= fetchGnt && redirect;
         if (redirect) begin
            pc <= redirectPc;
         end else if (fetchGnt) begin
            pc <= pc + wordWidth'(2);
         end
         if (redirect) begin
            bufValid <= 1'b0;
         end else if (liveRet) begin
            bufValid <= 1'b1;
         end else if (instrTake) begin
            bufValid <= 1'b0;
         end
      end
   end

   // PC has already moved past the returning word
   always_ff @(posedge clk) begin
      if (liveRet) begin
         instr <= rdata;
         pcNext <= pc;
      end
   end

endmodule

/* logic/memArbiter.sv */
// Fixed-priority arbiter giving loader, data port and fetch access to the memory
`timescale 1ns/1ns
module memArbiter import procPkg::*; #(
   parameter int memWords = 256,
   localparam int addrBits = $clog2(memWords)
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 loadReq,
   input  logic [wordWidth-1:0] loadAddr,
   input  logic [wordWidth-1:0] loadData,
   output logic                 loadGnt,
   input  logic                 dataReq,
   input  logic                 dataWe,
   input  logic [wordWidth-1:0] dataAddr,
   input  logic [wordWidth-1:0] dataWdata,
   output logic                 dataGnt,
   output logic                 dataRdValid,
   input  logic                 fetchReq,
   input  logic [wordWidth-1:0] fetchAddr,
   output logic                 fetchGnt,
   output logic                 fetchRdValid,
   output logic                 memEn,
   output logic                 memWe,
   output logic [addrBits-1:0]  memAddr,
   output logic [wordWidth-1:0] memWdata
);

   // Loader first, then data, then fetch
   always_comb begin
      loadGnt = loadReq;
      dataGnt = dataReq && !loadReq;
      fetchGnt = fetchReq && !loadReq && !dataReq;
      memEn = loadReq || dataReq || fetchReq;
      memWe = loadReq || (dataGnt && dataWe);
      // Byte address to word index
      if (loadReq) begin
         memAddr = loadAddr[addrBits:1];
         memWdata = loadData;
      end else if (dataReq) begin
         memAddr = dataAddr[addrBits:1];
         memWdata = dataWdata;
      end else begin
         memAddr = fetchAddr[addrBits:1];
         memWdata = '0;
      end
   end

   // Steer next cycle's read data to whoever was granted the read
   always_ff @(posedge clk) begin
      if (reset) begin
         dataRdValid <= 1'b0;
         fetchRdValid <= 1'b0;
      end else begin
         dataRdValid <= dataGnt && !dataWe;
         fetchRdValid <= fetchGnt;
      end
   end

endmodule

/* logic/memStage.sv */
// Memory stage issuing load and store requests and picking the writeback value
`timescale 1ns/1ns
module memStage import procPkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 memStart,
   input  logic                 isLoad,
   input  logic                 isStore,
   input  logic [wordWidth-1:0] addr,
   input  logic [wordWidth-1:0] storeData,
   input  logic [wordWidth-1:0] aluResult,
   output logic                 dataReq,
   output logic                 dataWe,
   output logic [wordWidth-1:0] dataAddr,
   output logic [wordWidth-1:0] dataWdata,
   input  logic                 dataGnt,
   input  logic                 dataRdValid,
   input  logic [wordWidth-1:0] rdata,
   output logic                 memDone,
   output logic [wordWidth-1:0] wbValue,
   output logic                 stValid,
   output logic [wordWidth-1:0] stAddr,
   output logic [wordWidth-1:0] stData
);

   logic busy;
   logic [wordWidth-1:0] loadWord;

   // Operands stay stable from decode until writeback, so the request holds
   assign dataReq = busy;
   assign dataWe = isStore;
   assign dataAddr = addr;
   assign dataWdata = storeData;

   // Stores finish at the grant, loads when the data comes back
   assign stValid = dataGnt && isStore;
   assign stAddr = addr;
   assign stData = storeData;
   assign memDone = stValid || dataRdValid;
   assign wbValue = isLoad ? loadWord : aluResult;

   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
      end else if (memStart) begin
         busy <= 1'b1;
      end else if (dataGnt) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (dataRdValid) begin
         loadWord <= rdata;
      end
   end

endmodule

/* logic/proc.sv */
// Top level of the 16-bit multi-cycle core with its shared program and data memory
`timescale 1ns/1ns
module proc import procPkg::*; #(
   parameter int memWords = 256
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 run,
   input  logic                 loadReq,
   input  logic [wordWidth-1:0] loadAddr,
   input  logic [wordWidth-1:0] loadData,
   output logic                 loadGnt,
   output logic                 wbValid,
   output logic [regSel-1:0]    wbReg,
   output logic [wordWidth-1:0] wbData,
   output logic                 stValid,
   output logic [wordWidth-1:0] stAddr,
   output logic [wordWidth-1:0] stData,
   output logic                 halted,
   output logic                 err
);

   localparam int addrBits = $clog2(memWords);

   logic memEn, memWe;
   logic [addrBits-1:0] memAddr;
   logic [wordWidth-1:0] memWdata, rdata;
   logic dataReq, dataWe, dataGnt, dataRdValid;
   logic [wordWidth-1:0] dataAddr, dataWdata;
   logic fetchReq, fetchGnt, fetchRdValid;
   logic [wordWidth-1:0] fetchAddr;
   logic instrValid, instrTake, redirect;
   logic [wordWidth-1:0] instr, pcNext, redirectPc;
   logic [wordWidth-1:0] rsData, rtData, instrEx, pcEx;
   aluOpT aluOp;
   logic takeBranch;
   logic [wordWidth-1:0] result, target, wbValue;
   logic memStart, isLoad, isStore, memDone;

   unifiedMem #(.memWords(memWords)) memory0 (
      .clk, .reset, .en(memEn), .we(memWe), .addr(memAddr), .wdata(memWdata), .rdata
   );

   memArbiter #(.memWords(memWords)) arbiter0 (
      .clk, .reset, .loadReq, .loadAddr, .loadData, .loadGnt,
      .dataReq, .dataWe, .dataAddr, .dataWdata, .dataGnt, .dataRdValid,
      .fetchReq, .fetchAddr, .fetchGnt, .fetchRdValid,
      .memEn, .memWe, .memAddr, .memWdata
   );

   fetch fetch0 (
      .clk, .reset, .run, .fetchReq, .fetchAddr, .fetchGnt, .fetchRdValid, .rdata,
      .instrTake, .redirect, .redirectPc, .instrValid, .instr, .pcNext
   );

   decode decode0 (
      .clk, .reset, .run, .instrValid, .instr, .pcNext, .instrTake, .redirect, .redirectPc,
      .rsData, .rtData, .aluOp, .instrOut(instrEx), .pcOut(pcEx),
      .takeBranch, .target, .result, .memStart, .isLoad, .isStore, .memDone, .wbValue,
      .wbValid, .wbReg, .wbData, .halted, .err
   );

   execute execute0 (
      .instr(instrEx), .rsData, .rtData, .aluOp, .pcNext(pcEx), .result, .takeBranch, .target
   );

   memStage memory1 (
      .clk, .reset, .memStart, .isLoad, .isStore, .addr(result), .storeData(rtData),
      .aluResult(result), .dataReq, .dataWe, .dataAddr, .dataWdata, .dataGnt, .dataRdValid,
      .rdata, .memDone, .wbValue, .stValid, .stAddr, .stData
   );

endmodule

/* logic/procPkg.sv */
// Shared types, instruction field positions and widths for the 16-bit multi-cycle core
package procPkg;

   localparam int wordWidth = 16;
   localparam int regSel = 3;

   // Lowest bit of each instruction field
   localparam int opLo = 11;    // opcode in 15:11
   localparam int rsLo = 8;     // rs in 10:8 for I-format, R-format, branches and LBI
   localparam int iRdLo = 5;    // I-format rd in 7:5
   localparam int rtLo = 5;     // R-format rt in 7:5
   localparam int rRdLo = 2;    // R-format rd in 4:2

   // Immediates all start at bit 0
   localparam int imm5Bits = 5;
   localparam int imm8Bits = 8;    // BEQZ, BNEZ and LBI, signed
   localparam int imm11Bits = 11;  // J, signed

   // Any other 5-bit value in 15:11 is illegal
   typedef enum logic [4:0] {
      HALT = 5'b00000,
      J    = 5'b00100,
      ADDI = 5'b01000,
      SUBI = 5'b01001,
      XORI = 5'b01010,
      BEQZ = 5'b01100,
      BNEZ = 5'b01101,
      ST   = 5'b10000,
      LD   = 5'b10001,
      LBI  = 5'b11000,
      ADD  = 5'b11011,
      SUB  = 5'b11100,
      XOR  = 5'b11101
   } opcodeT;

   typedef enum logic [2:0] {
      sIdle,
      sDecode,
      sExecute,
      sMemory,
      sWriteback,
      sHalt
   } ctrlStateT;

   typedef enum logic [1:0] {
      aluAdd,
      aluSub,
      aluXor
   } aluOpT;

endpackage

/* logic/unifiedMem.sv */
// Unified program and data memory, single port with registered read data
`timescale 1ns/1ns
module unifiedMem import procPkg::*; #(
   parameter int memWords = 256,
   localparam int addrBits = $clog2(memWords)
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 en,
   input  logic                 we,
   input  logic [addrBits-1:0]  addr,
   input  logic [wordWidth-1:0] wdata,
   output logic [wordWidth-1:0] rdata
);

   logic [wordWidth-1:0] mem [memWords];

   always_ff @(posedge clk) begin
      if (en && we) begin
         mem[addr] <= wdata;
      end
   end

   // Read data shows up the cycle after the access
   always_ff @(posedge clk) begin
      if (reset) begin
         rdata <= '0;
      end else if (en && !we) begin
         rdata <= mem[addr];
      end
   end

endmodule

/* vlog.f */
logic/procPkg.sv
logic/unifiedMem.sv
logic/memArbiter.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/memStage.sv
logic/proc.sv
bench/clockGen.sv
bench/procTb.sv
